//--- build.f
sramPkg.sv
sramAddrDecode.sv
sramBank.sv
sramColumn.sv
sramTile.sv
tbSramTile.sv

//--- run.sh
#!/bin/sh
# Compile and run the SRAM tile testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert \
  --top-module tbSramTile \
  -f build.f \
  --Mdir obj_dir \
  -o simSramTile

./obj_dir/simSramTile | tee "$LOG"

if grep -q "^Result: PASSED$" "$LOG"; then
  exit 0
else
  exit 1
fi

//--- sramAddrDecode.sv
// ##########################################################
// Request decoder that splits the word address into bank
// select and row and forms the read and write strobes
// ##########################################################

`timescale 1ns/1ps

module sramAddrDecode #(
  parameter int unsigned NumWords = 256
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              req_i,
  input  logic              we_i,
  input  sramPkg::addr_t    addr_i,
  input  sramPkg::be_t      be_i,
  input  sramPkg::word_t    wdata_i,
  output sramPkg::bankCmd_t cmd_o
);

  import sramPkg::*;

  logic wrReq;
  logic rdReq;

  assign wrReq = req_i && we_i;
  assign rdReq = req_i && !we_i;

  always_comb begin
    cmd_o.rd    = rdReq;
    cmd_o.wr    = wrReq;
    cmd_o.sel   = addr_i[AddrWidth-1 -: $bits(bankSel_t)]; // Upper bits pick the bank
    cmd_o.row   = addr_i[BankAddrWidth-1:0];
    cmd_o.be    = wrReq ? be_i : '0;                       // No byte lanes on reads
    cmd_o.wdata = wdata_i;
  end

  // Anything at or above NumWords lands in a bank that does not exist
  addrInRange: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    req_i |-> (32'(addr_i) < NumWords)
  ) else $warning("Request address %0h not mapped (NumWords %0d)", addr_i, NumWords);

endmodule

//--- sramBank.sv
// ##########################################################
// Behavioral 64-word block-RAM bank with byte write
// masking and a registered read port
// ##########################################################

`timescale 1ns/1ps

module sramBank #(
  parameter int unsigned Width = 64
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 rd_i,
  input  logic                 wr_i,
  input  sramPkg::bankRow_t    row_i,
  input  logic [Width/8-1:0]   be_i,
  input  logic [Width-1:0]     wdata_i,
  output logic [Width-1:0]     rdata_o
);

  import sramPkg::*;

  localparam int unsigned NumBytes = Width / ByteWidth;

  // Storage starts cleared
  logic [Width-1:0] mem [BankWords] = '{default: '0};
  logic [Width-1:0] rdataQ;

  // Byte-masked write port
  always_ff @(posedge clk_i) begin
    if (wr_i) begin
      for (int b = 0; b < NumBytes; b++) begin
        if (be_i[b]) begin
          mem[row_i][b*ByteWidth +: ByteWidth] <= wdata_i[b*ByteWidth +: ByteWidth];
        end
      end
    end
  end

  // Output register holds the last read until the next one
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdataQ <= '0;
    end else if (rd_i) begin
      rdataQ <= mem[row_i];
    end
  end

  assign rdata_o = rdataQ;

  // The decoder never issues both strobes for one request
  noRdWrOverlap: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !(rd_i && wr_i)
  ) else $error("Bank got read and write strobes in the same cycle");

endmodule

//--- sramColumn.sv
// ##########################################################
// One column of stacked banks with the registered bank
// select and the read data multiplexer
// ##########################################################

`timescale 1ns/1ps

module sramColumn #(
  parameter int unsigned NumWords = 256,
  parameter int unsigned ColLsb   = 0,
  parameter int unsigned ColWidth = 64
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  sramPkg::bankCmd_t   cmd_i,
  output logic [ColWidth-1:0] rdata_o
);

  import sramPkg::*;

  localparam int unsigned NumBanks = NumWords / BankWords;
  localparam int unsigned SelBits  = (NumBanks > 1) ? $clog2(NumBanks) : 1;
  localparam int unsigned ColBytes = ColWidth / ByteWidth;

  if (NumBanks > MaxBanks) begin : genTooManyBanks
    $fatal(1, "Column needs %0d banks, limit is %0d", NumBanks, MaxBanks);
  end

  logic [ColBytes-1:0] colBe;
  logic [ColWidth-1:0] colWdata;
  logic [ColWidth-1:0] bankRdata [NumBanks];
  bankSel_t            selQ;   // Bank of the last read

  // This column's share of the word
  assign colBe    = cmd_i.be[ColLsb/ByteWidth +: ColBytes];
  assign colWdata = cmd_i.wdata[ColLsb +: ColWidth];

  for (genvar y = 0; y < NumBanks; y++) begin : genBank
    sramBank #(
      .Width  (ColWidth)
    ) bank_inst (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .rd_i    (cmd_i.rd && (cmd_i.sel == bankSel_t'(y))), // Only the addressed bank
      .wr_i    (cmd_i.wr && (cmd_i.sel == bankSel_t'(y))),
      .row_i   (cmd_i.row),
      .be_i    (colBe),
      .wdata_i (colWdata),
      .rdata_o (bankRdata[y])
    );
  end

  // Bank select follows each read so it lines up with data one edge later
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      selQ <= '0;
    end else if (cmd_i.rd) begin
      selQ <= cmd_i.sel;
    end
  end

  assign rdata_o = bankRdata[selQ[SelBits-1:0]];

  // A read outside the stack would return the wrong bank's word
  selInColumn: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    cmd_i.rd |-> (32'(cmd_i.sel) < NumBanks)
  ) else $error("Read bank select %0d beyond %0d banks", cmd_i.sel, NumBanks);

endmodule

//--- sramPkg.sv
// ##########################################################
// Widths, vector types and the bank command struct
// shared by the banked SRAM tile
// ##########################################################

package sramPkg;

  // Memory word geometry
  localparam int unsigned DataWidth = 96;
  localparam int unsigned ByteWidth = 8;
  localparam int unsigned BeWidth   = DataWidth / ByteWidth; // 12 byte lanes

  // One block-RAM bank
  localparam int unsigned BankWidth     = 64;
  localparam int unsigned BankWords     = 64;
  localparam int unsigned BankAddrWidth = $clog2(BankWords);

  // Largest stack of banks a column may hold
  localparam int unsigned MaxBanks = 8;

  // Word address covers MaxBanks full banks
  localparam int unsigned AddrWidth = $clog2(MaxBanks * BankWords);

  typedef logic [DataWidth-1:0]         word_t;
  typedef logic [BeWidth-1:0]           be_t;
  typedef logic [AddrWidth-1:0]         addr_t;
  typedef logic [BankAddrWidth-1:0]     bankRow_t;
  typedef logic [$clog2(MaxBanks)-1:0]  bankSel_t;

  // Decoded request, broadcast to every column
  typedef struct packed {
    logic     rd;     // Read strobe
    logic     wr;     // Write strobe
    bankSel_t sel;    // Bank within the column
    bankRow_t row;    // Row within the bank
    be_t      be;     // Byte enables cleared unless writing
    word_t    wdata;  // Full write word
  } bankCmd_t;

endpackage

//--- sramTestdata.txt
// op (0 idle, 1 write, 2 read, 3 group end, F end) | addr | be | wdata | expected rdata
// expected is checked one cycle after a read and must hold until the next read
2 000 000 000000000000000000000000 000000000000000000000000
2 041 000 000000000000000000000000 000000000000000000000000
2 0C5 000 000000000000000000000000 000000000000000000000000
2 0FF 000 000000000000000000000000 000000000000000000000000
3 000 000 000000000000000000000000 000000000000000000000000
1 010 FFF 111122223333444455556666 000000000000000000000000
1 0A7 FFF DEADBEEFCAFEF00D01234567 000000000000000000000000
2 010 000 000000000000000000000000 111122223333444455556666
2 0A7 000 000000000000000000000000 DEADBEEFCAFEF00D01234567
3 000 000 000000000000000000000000 000000000000000000000000
1 020 FFF AAAAAAAABBBBBBBBCCCCCCCC 000000000000000000000000
2 020 000 000000000000000000000000 AAAAAAAABBBBBBBBCCCCCCCC
1 020 801 00112233445566778899AABB 000000000000000000000000
1 020 0F0 000000001234567800000000 000000000000000000000000
1 020 000 FFFFFFFFFFFFFFFFFFFFFFFF 000000000000000000000000
2 020 000 000000000000000000000000 00AAAAAA12345678CCCCCCBB
3 000 000 000000000000000000000000 000000000000000000000000
1 03F FFF 03F03F03F03F03F03F03F03F 000000000000000000000000
1 040 FFF 040040040040040040040040 000000000000000000000000
1 07F FFF 07F07F07F07F07F07F07F07F 000000000000000000000000
1 080 FFF 080080080080080080080080 000000000000000000000000
1 0FF FFF 0FF0FF0FF0FF0FF0FF0FF0FF 000000000000000000000000
2 0FF 000 000000000000000000000000 0FF0FF0FF0FF0FF0FF0FF0FF
2 03F 000 000000000000000000000000 03F03F03F03F03F03F03F03F
2 080 000 000000000000000000000000 080080080080080080080080
2 040 000 000000000000000000000000 040040040040040040040040
2 07F 000 000000000000000000000000 07F07F07F07F07F07F07F07F
3 000 000 000000000000000000000000 000000000000000000000000
1 030 FFF 5A5A5A5A5A5A5A5A5A5A5A5A 000000000000000000000000
2 030 000 000000000000000000000000 5A5A5A5A5A5A5A5A5A5A5A5A
2 010 000 000000000000000000000000 111122223333444455556666
2 0A7 000 000000000000000000000000 DEADBEEFCAFEF00D01234567
2 020 000 000000000000000000000000 00AAAAAA12345678CCCCCCBB
1 030 FFF C3C3C3C3C3C3C3C3C3C3C3C3 000000000000000000000000
2 030 000 000000000000000000000000 C3C3C3C3C3C3C3C3C3C3C3C3
3 000 000 000000000000000000000000 000000000000000000000000
2 03F 000 000000000000000000000000 03F03F03F03F03F03F03F03F
0 000 000 000000000000000000000000 000000000000000000000000
1 041 FFF 777777777777777777777777 000000000000000000000000
0 000 000 000000000000000000000000 000000000000000000000000
1 0FF FFF 999999999999999999999999 000000000000000000000000
0 000 000 000000000000000000000000 000000000000000000000000
2 0FF 000 000000000000000000000000 999999999999999999999999
2 041 000 000000000000000000000000 777777777777777777777777
3 000 000 000000000000000000000000 000000000000000000000000
F 000 000 000000000000000000000000 000000000000000000000000

//--- sramTile.sv
// ##########################################################
// Top level SRAM tile with the decoder feeding a 64-bit
// column and a 32-bit remainder column
// ##########################################################

`timescale 1ns/1ps

module sramTile #(
  parameter int unsigned NumWords = 256
) (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  logic           req_i,
  input  logic           we_i,
  input  sramPkg::addr_t addr_i,
  input  sramPkg::be_t   be_i,
  input  sramPkg::word_t wdata_i,
  output sramPkg::word_t rdata_o
);

  import sramPkg::*;

  localparam int unsigned LowWidth  = BankWidth;              // Full bank column
  localparam int unsigned HighWidth = DataWidth - BankWidth;  // Remainder column

  bankCmd_t cmd;

  sramAddrDecode #(
    .NumWords (NumWords)
  ) sramAddrDecode_inst (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .req_i   (req_i),
    .we_i    (we_i),
    .addr_i  (addr_i),
    .be_i    (be_i),
    .wdata_i (wdata_i),
    .cmd_o   (cmd)
  );

  sramColumn #(
    .NumWords (NumWords),
    .ColLsb   (0),
    .ColWidth (LowWidth)
  ) colLow_inst (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .cmd_i   (cmd),
    .rdata_o (rdata_o[0 +: LowWidth])
  );

  sramColumn #(
    .NumWords (NumWords),
    .ColLsb   (LowWidth),
    .ColWidth (HighWidth)
  ) colHigh_inst (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .cmd_i   (cmd),
    .rdata_o (rdata_o[LowWidth +: HighWidth])
  );

endmodule

//--- tbSramTile.sv
// ##########################################################
// Testbench for the SRAM tile that replays the vectors of
// the test data file and checks the read data every cycle
// ##########################################################

`timescale 1ns/1ps

module tbSramTile;

  import sramPkg::*;

  localparam int unsigned MaxVectors = 64;
  localparam int unsigned Fields     = 5;     // op, addr, be, wdata, expected

  // Opcodes of the data file
  localparam logic [3:0] OpWrite = 4'h1;
  localparam logic [3:0] OpRead  = 4'h2;
  localparam logic [3:0] OpGroup = 4'h3;   // Idle cycle that closes a test group
  localparam logic [3:0] OpEnd   = 4'hF;

  logic  clk;
  logic  rstN;
  logic  req;
  logic  we;
  addr_t addr;
  be_t   be;
  word_t wdata;
  word_t rdata;

  word_t       vecMem [MaxVectors*Fields];
  int unsigned cycleLimit;
  int unsigned cycleCount;
  int unsigned checkCount;
  int unsigned errorCount;
  int unsigned groupErrors;
  int unsigned groupCount;
  int unsigned groupsPassed;

  sramTile #(
    .NumWords (256)
  ) sramTile_inst (
    .clk_i   (clk),
    .rst_ni  (rstN),
    .req_i   (req),
    .we_i    (we),
    .addr_i  (addr),
    .be_i    (be),
    .wdata_i (wdata),
    .rdata_o (rdata)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #10 clk = ~clk;   // 20 ns period
    end
  end

  task automatic checkWord(input string name, input word_t expVal, input word_t actVal);
    checkCount++;
    if (actVal !== expVal) begin
      errorCount++;
      groupErrors++;
      $display("Error: time %0t, %s expected %h, actual %h", $time, name, expVal, actVal);
    end
  endtask

  task automatic driveIdle();
    req   = 1'b0;
    we    = 1'b0;
    addr  = '0;
    be    = '0;
    wdata = '0;
  endtask

  task automatic applyVector(input int unsigned idx);
    logic [3:0] op;
    op    = vecMem[idx*Fields][3:0];
    req   = (op == OpWrite) || (op == OpRead);
    we    = (op == OpWrite);
    addr  = addr_t'(vecMem[idx*Fields+1]);
    be    = be_t'(vecMem[idx*Fields+2]);
    wdata = vecMem[idx*Fields+3];
  endtask

  task automatic closeGroup();
    groupCount++;
    if (groupErrors == 0) begin
      groupsPassed++;
      $display("Test group %0d: pass", groupCount);
    end else begin
      $display("Test group %0d: fail, %0d mismatches", groupCount, groupErrors);
    end
    groupErrors = 0;
  endtask

  initial begin
    word_t       holdExp;   // Value rdata must show until the next read
    word_t       pendExp;
    logic        pendRead;
    logic [3:0]  op;
    int unsigned idx;
    int unsigned numVectors;
    rstN = 1'b0;
    driveIdle();
    checkCount   = 0;
    errorCount   = 0;
    groupErrors  = 0;
    groupCount   = 0;
    groupsPassed = 0;

    // Unfilled entries read as end markers
    for (idx = 0; idx < MaxVectors*Fields; idx++) begin
      vecMem[idx] = '1;
    end
    $readmemh("sramTestdata.txt", vecMem);
    numVectors = 0;
    while (numVectors < MaxVectors && vecMem[numVectors*Fields][3:0] != OpEnd) begin
      numVectors++;
    end
    cycleLimit = (numVectors + 1) * 2 + 100;

    repeat (16) @(posedge clk);
    #2;
    rstN = 1'b1;

    holdExp  = '0;
    pendExp  = '0;
    pendRead = 1'b0;
    idx      = 0;
    op       = 4'h0;
    while (op != OpEnd) begin
      @(posedge clk);
      #2;                         // Drive point of this cycle with registers settled
      if (pendRead) begin
        holdExp = pendExp;
      end
      checkWord("rdata_o", holdExp, rdata);
      op = (idx < MaxVectors) ? vecMem[idx*Fields][3:0] : OpEnd;
      if (op == OpGroup) begin
        closeGroup();
      end
      if (op == OpEnd) begin
        driveIdle();
        pendRead = 1'b0;
      end else begin
        applyVector(idx);
        pendRead = (op == OpRead);
        pendExp  = vecMem[idx*Fields+4];
      end
      idx++;
    end

    $display("Checks %0d, errors %0d, groups passed %0d of %0d",
             checkCount, errorCount, groupsPassed, groupCount);
    if (errorCount == 0 && groupCount > 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  // Cycle budget derived from the vector count
  initial begin
    cycleCount = 0;
    wait (cycleLimit != 0);
    while (cycleCount < cycleLimit) begin
      @(posedge clk);
      cycleCount++;
    end
    $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
    $display("Result: FAILED");
    $finish;
  end

endmodule
